//--- src/bg_pkg.sv
// ---------------------------------------------------------------------------
// Shared constants for the tile background renderer.
// Tiles are 16x16 pixels at 4 bpp; one 16-bit word holds four pixels,
// so a tile row is four words and a whole tile is 64 words.
// buf_words() sizes a scanline buffer: one extra tile column for fine scroll.
// ---------------------------------------------------------------------------
package bg_pkg;

	localparam logic [3:0] REG_CTRL     = 4'd0;
	localparam logic [3:0] REG_SCROLL_X = 4'd1;
	localparam logic [3:0] REG_SCROLL_Y = 4'd2;
	localparam logic [3:0] REG_MAP_BASE = 4'd3;
	localparam logic [3:0] REG_SET_BASE = 4'd4;

	// control word fields
	localparam int CTRL_EN_BIT     = 0;
	localparam int CTRL_PAL_LSB    = 4;	// 4 bits
	localparam int CTRL_STRIDE_LSB = 8;	// 2 bits, 0 = 256 tiles per row

	localparam int TILE_PIX       = 16;
	localparam int WORDS_PER_TILE = 64;
	localparam logic [7:0] TRANSPARENT_TILE = 8'hff;

	typedef enum logic [2:0] {
		F_IDLE,
		F_BEGIN,
		F_MAP_REQ,
		F_DATA_REQ,
		F_ADVANCE
	} fetch_state_t;

	function automatic int buf_words(int screen_w);
		return (screen_w / TILE_PIX + 1) * (WORDS_PER_TILE / TILE_PIX);
	endfunction

endpackage

//--- src/mem_rd_if.sv
// ---------------------------------------------------------------------------
// Memory read channel towards the external arbiter.
// valid rises with a word address and both hold until ready; data is
// sampled in the ready cycle, which also ends the request.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

interface mem_rd_if;
	logic [15:0] address;	// word address
	logic [15:0] data;
	logic        valid;
	logic        ready;

	modport fetch (output address, output valid, input data, input ready);

	modport top (input address, input valid, output data, output ready);

endinterface

//--- src/bram.sv
// ---------------------------------------------------------------------------
// Simple dual-port RAM, one write port and one registered read port.
// A read and a write to the same address in one cycle return the old word.
// Contents start at zero; there is no reset.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module bram #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_addr,
	output logic [BITS-1:0]         rd_data,
	input  logic [ADDRESS_BITS-1:0] wr_addr,
	input  logic [BITS-1:0]         wr_data,
	input  logic                    wr
);

	logic [BITS-1:0] mem [2**ADDRESS_BITS] = '{default: '0};

	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

//--- src/bg_regs.sv
// ---------------------------------------------------------------------------
// CPU configuration registers of the background layer.
// A write is visible on the outputs in the cycle after WR.
// Addresses above REG_SET_BASE are ignored; all registers clear on reset.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module bg_regs (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [3:0]  ADDRESS,
	input  logic [15:0] DATA_IN,
	input  logic        WR,
	output logic        enable,
	output logic [3:0]  pal_hi,
	output logic [1:0]  stride,
	output logic [15:0] scroll_x,
	output logic [15:0] scroll_y,
	output logic [15:0] map_base,
	output logic [15:0] set_base
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable   <= 1'b0;
			pal_hi   <= 4'd0;
			stride   <= 2'd0;
			scroll_x <= 16'h0000;
			scroll_y <= 16'h0000;
			map_base <= 16'h0000;
			set_base <= 16'h0000;
		end else if (WR) begin
			case (ADDRESS)
				bg_pkg::REG_CTRL: begin
					enable <= DATA_IN[bg_pkg::CTRL_EN_BIT];
					pal_hi <= DATA_IN[bg_pkg::CTRL_PAL_LSB +: 4];
					stride <= DATA_IN[bg_pkg::CTRL_STRIDE_LSB +: 2];
				end
				bg_pkg::REG_SCROLL_X: scroll_x <= DATA_IN;
				bg_pkg::REG_SCROLL_Y: scroll_y <= DATA_IN;
				bg_pkg::REG_MAP_BASE: map_base <= DATA_IN;	// word address
				bg_pkg::REG_SET_BASE: set_base <= DATA_IN;
				default: ;
			endcase
		end
	end

endmodule

//--- src/tile_fetch.sv
// ---------------------------------------------------------------------------
// Per-line tile fetch engine.
// Starts on h_tick with enable high and fetches SCREEN_W/16+1 tile columns
// into the fill buffer. With ready always high a tile costs 7 cycles,
// a transparent one 3. Map addresses wrap at 17 bits (byte), data at 16.
// An h_tick during a line restarts it and abandons any open request.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module tile_fetch #(
	parameter int  SCREEN_W = 320,
	localparam int AW       = $clog2(bg_pkg::buf_words(SCREEN_W))
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          h_tick,
	input  logic [9:0]    display_y,
	input  logic          enable,
	input  logic [1:0]    stride,
	input  logic [15:0]   scroll_x,
	input  logic [15:0]   scroll_y,
	input  logic [15:0]   map_base,
	input  logic [15:0]   set_base,
	mem_rd_if.fetch       mem,
	output logic [AW-1:0] wr_addr,
	output logic [15:0]   wr_data,
	output logic          wr_en,
	output logic          line_start
);

	localparam int NCOL      = SCREEN_W / bg_pkg::TILE_PIX + 1;
	localparam int CW        = AW - 2;
	localparam int ROW_WORDS = bg_pkg::WORDS_PER_TILE / bg_pkg::TILE_PIX;

	bg_pkg::fetch_state_t state;

	logic [9:0]    line_y;
	logic [CW-1:0] col;
	logic [1:0]    quarter;
	logic [16:0]   map_byte;	// byte address of the current map entry
	logic [7:0]    tile;
	logic [15:0]   addr_r;
	logic          valid_r;

	logic [15:0] y_pos;
	logic [3:0]  pix_row;
	logic [11:0] map_row;
	logic [16:0] row_offset;
	logic [16:0] line_map;
	logic [16:0] next_map;
	logic [15:0] tile_word;

	assign line_start = h_tick && enable;

	always_comb begin
		y_pos      = scroll_y + {6'd0, line_y};
		pix_row    = y_pos[3:0];
		map_row    = y_pos[15:4];
		// row * stride, stride code n means 256 >> n tiles per row
		row_offset = 17'({map_row, 8'd0} >> stride);
		line_map   = {map_base, 1'b0} + row_offset + {5'd0, scroll_x[15:4]};
		next_map   = map_byte + 17'd1;
		tile_word  = set_base + 16'(tile) * 16'(bg_pkg::WORDS_PER_TILE)
			+ 16'(pix_row) * 16'(ROW_WORDS);
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state   <= bg_pkg::F_IDLE;
			valid_r <= 1'b0;
		end else if (line_start) begin
			state   <= bg_pkg::F_BEGIN;
			valid_r <= 1'b0;
			line_y  <= display_y;
		end else begin
			case (state)
				bg_pkg::F_IDLE: ;
				bg_pkg::F_BEGIN: begin
					map_byte <= line_map;
					addr_r   <= line_map[16:1];
					col      <= '0;
					valid_r  <= 1'b1;
					state    <= bg_pkg::F_MAP_REQ;
				end
				bg_pkg::F_MAP_REQ: if (mem.ready) begin
					tile    <= map_byte[0] ? mem.data[15:8] : mem.data[7:0];
					valid_r <= 1'b0;
					state   <= bg_pkg::F_DATA_REQ;
				end
				bg_pkg::F_DATA_REQ: begin
					if (!valid_r) begin	// setup cycle
						if (tile == bg_pkg::TRANSPARENT_TILE) begin
							state <= bg_pkg::F_ADVANCE;
						end else begin
							addr_r  <= tile_word;
							quarter <= 2'd0;
							valid_r <= 1'b1;
						end
					end else if (mem.ready) begin
						addr_r  <= addr_r + 16'd1;
						quarter <= quarter + 2'd1;
						if (quarter == 2'd3) begin
							valid_r <= 1'b0;
							state   <= bg_pkg::F_ADVANCE;
						end
					end
				end
				bg_pkg::F_ADVANCE: begin
					if (col == CW'(NCOL - 1)) begin
						state <= bg_pkg::F_IDLE;
					end else begin
						col      <= col + 1'b1;
						map_byte <= next_map;
						addr_r   <= next_map[16:1];
						valid_r  <= 1'b1;
						state    <= bg_pkg::F_MAP_REQ;
					end
				end
				default: state <= bg_pkg::F_IDLE;
			endcase
		end
	end

	assign mem.address = addr_r;
	assign mem.valid   = valid_r;

	// data words go straight into the fill buffer
	assign wr_en   = (state == bg_pkg::F_DATA_REQ) && valid_r && mem.ready;
	assign wr_addr = {col, quarter};
	assign wr_data = mem.data;

endmodule

//--- src/scanline_store.sv
// ---------------------------------------------------------------------------
// Ping-pong scanline buffers; line_start swaps fill and display roles.
// color_index follows display_x by two cycles and is zero while re is low.
// Assumes display_x steps by one per cycle while re is high. Read words are
// zeroed once passed; words outside the scrolled window are zeroed early.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module scanline_store #(
	parameter int  SCREEN_W = 320,
	localparam int AW       = $clog2(bg_pkg::buf_words(SCREEN_W))
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          line_start,
	input  logic [AW-1:0] wr_addr,
	input  logic [15:0]   wr_data,
	input  logic          wr_en,
	input  logic [9:0]    display_x,
	input  logic          re,
	input  logic [3:0]    pal_hi,
	input  logic [3:0]    scroll_x,	// fine scroll only
	output logic [7:0]    color_index
);

	localparam int VIS_WORDS = SCREEN_W / 4;	// four pixels per word

	logic          disp_sel;
	logic          buf_r;
	logic          re_r;
	logic [AW-1:0] word_r;
	logic [1:0]    nib_r;
	logic [15:0]   rd_data [2];

	logic [9:0]    pos;
	logic [9:0]    last_pos;
	logic [AW-1:0] rd_word;
	logic [AW-1:0] dx_word;
	logic [AW-1:0] hi_word;
	logic          clr_en;
	logic [AW-1:0] clr_addr;

	always_comb begin
		pos      = display_x + {6'd0, scroll_x};
		last_pos = 10'(SCREEN_W - 1) + {6'd0, scroll_x};
		rd_word  = pos[AW+1:2];
		dx_word  = display_x[AW+1:2];
		hi_word  = dx_word + AW'(VIS_WORDS);

		clr_en   = 1'b0;
		clr_addr = word_r;
		if (re_r && (!re || rd_word != word_r)) begin
			clr_en = 1'b1;	// leaving word_r
		end else if (re && !display_x[0] && dx_word < rd_word) begin
			clr_en   = 1'b1;	// left of the window
			clr_addr = dx_word;
		end else if (re && display_x[0] && display_x < 10'(bg_pkg::TILE_PIX)
				&& hi_word > last_pos[AW+1:2]) begin
			clr_en   = 1'b1;	// right of the window, never read
			clr_addr = hi_word;
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_buf
		wire is_disp = (disp_sel == 1'(i));

		bram #(.BITS(16), .ADDRESS_BITS(AW)) u_ram (
			.CLK     (CLK),
			.rd_addr (rd_word),
			.rd_data (rd_data[i]),
			.wr_addr (is_disp ? clr_addr : wr_addr),
			.wr_data (is_disp ? 16'h0000 : wr_data),
			.wr      (is_disp ? clr_en : wr_en)
		);
	end

	always_ff @(posedge CLK) begin
		word_r <= rd_word;
		nib_r  <= pos[1:0];
		buf_r  <= disp_sel;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			disp_sel    <= 1'b0;
			re_r        <= 1'b0;
			color_index <= 8'h00;
		end else begin
			if (line_start)
				disp_sel <= ~disp_sel;
			re_r        <= re;
			color_index <= re_r ? {pal_hi, rd_data[buf_r][nib_r*4 +: 4]} : 8'h00;
		end
	end

endmodule

//--- src/bg_renderer.sv
// ---------------------------------------------------------------------------
// Tile background renderer, single layer of 16x16 4 bpp tiles.
// SCREEN_W must be a multiple of 16 and at most 1008.
// memory_address is a 16-bit word address; the arbiter answers with rready.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module bg_renderer #(
	parameter int SCREEN_W = 320
) (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [3:0]  ADDRESS,
	input  logic [15:0] DATA_IN,
	input  logic        WR,
	input  logic        h_tick,
	input  logic [9:0]  display_x,
	input  logic [9:0]  display_y,
	input  logic        re,
	output logic [7:0]  color_index,
	output logic [15:0] memory_address,
	input  logic [15:0] memory_data,
	output logic        rvalid,
	input  logic        rready
);

	localparam int AW = $clog2(bg_pkg::buf_words(SCREEN_W));

	logic          enable;
	logic [3:0]    pal_hi;
	logic [1:0]    stride;
	logic [15:0]   scroll_x, scroll_y, map_base, set_base;
	logic [AW-1:0] wr_addr;
	logic [15:0]   wr_data;
	logic          wr_en;
	logic          line_start;

	mem_rd_if mem ();

	assign memory_address = mem.address;
	assign rvalid         = mem.valid;
	assign mem.data       = memory_data;
	assign mem.ready      = rready;

	bg_regs u_regs (
		.CLK, .RSTb, .ADDRESS, .DATA_IN, .WR,
		.enable, .pal_hi, .stride, .scroll_x, .scroll_y, .map_base, .set_base
	);

	tile_fetch #(.SCREEN_W(SCREEN_W)) u_fetch (
		.CLK, .RSTb, .h_tick, .display_y,
		.enable, .stride, .scroll_x, .scroll_y, .map_base, .set_base,
		.mem     (mem.fetch),
		.wr_addr, .wr_data, .wr_en, .line_start
	);

	scanline_store #(.SCREEN_W(SCREEN_W)) u_store (
		.CLK, .RSTb, .line_start, .wr_addr, .wr_data, .wr_en,
		.display_x, .re, .pal_hi,
		.scroll_x    (scroll_x[3:0]),
		.color_index
	);

endmodule

//--- tests/bg_renderer_assert.sv
// ---------------------------------------------------------------------------
// Concurrent checks bound into tile_fetch.
// A request holds valid and address until ready, unless a new line
// restarts the fetch. No request is open while the fetch is idle, and a
// transparent tile never writes the scanline buffer.
// fail_count is read by the testbench at the end.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module bg_renderer_assert (
	input logic                 CLK,
	input logic                 RSTb,
	input bg_pkg::fetch_state_t state,
	input logic                 line_start,
	input logic                 valid,
	input logic                 ready,
	input logic [15:0]          address,
	input logic [7:0]           tile,
	input logic                 wr_en
);

	int fail_count = 0;

	a_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		valid && !ready && !line_start |=> valid && $stable(address))
		else begin
			$error("request dropped or address moved before ready");
			fail_count++;
		end

	// covers the first cycles after reset too, the fetch sits in idle
	a_reset: assert property (@(posedge CLK) disable iff (!RSTb)
		state == bg_pkg::F_IDLE |-> !valid)
		else begin
			$error("valid high while fetch is idle");
			fail_count++;
		end

	a_opaque: assert property (@(posedge CLK) disable iff (!RSTb)
		wr_en |-> tile != bg_pkg::TRANSPARENT_TILE)
		else begin
			$error("scanline write for a transparent tile");
			fail_count++;
		end

endmodule

bind tile_fetch bg_renderer_assert u_assert (
	.CLK, .RSTb, .state, .line_start,
	.valid   (valid_r),
	.ready   (mem.ready),
	.address (addr_r),
	.tile,
	.wr_en
);

//--- tests/tb_bg_renderer.sv
// ---------------------------------------------------------------------------
// Directed tests for the tile background renderer.
// The memory model answers from a 64K word array, with zero or random delay.
// Expected pixels come from a reference of the map and tile rules.
// Each rendered line is fetched, shown after the next h_tick, and fetched
// again into the other buffer during the sweep, so buffer 0 is always shown.
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_bg_renderer;

	localparam int SCREEN_W  = 320;
	localparam int NCOL      = SCREEN_W / 16 + 1;
	localparam int MAX_DELAY = 3;
	localparam int LIMIT     = 13 * (2 * NCOL * 7 * (MAX_DELAY + 1) + SCREEN_W + 64);

	logic        CLK;
	logic        RSTb;
	logic [3:0]  ADDRESS;
	logic [15:0] DATA_IN;
	logic        WR;
	logic        h_tick;
	logic [9:0]  display_x;
	logic [9:0]  display_y;
	logic        re;
	logic [7:0]  color_index;
	logic [15:0] memory_address;
	logic [15:0] memory_data = 16'h0000;
	logic        rvalid;
	logic        rready = 1'b0;

	logic [15:0] mem_words [65536];
	logic [31:0] rng = 32'h7a5d_ae80;
	int          delay_max = 0;
	int          wait_cnt = 0;
	int          cur_delay = 0;
	int          hs_count = 0;
	int          ff_reqs = 0;
	int          hs_base;
	int          ff_base;
	int          cycles = 0;
	int          errors;
	int          test_errs;
	int          tests_run;

	// register contents as last written
	logic [3:0]  cfg_pal;
	logic [1:0]  cfg_stride;
	logic [15:0] cfg_sx, cfg_sy, cfg_mb, cfg_sb;

	bg_renderer #(.SCREEN_W(SCREEN_W)) i_bg_renderer (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout after %0d cycles, the fetch never finished", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// memory model, ready after cur_delay waiting cycles
	always @(negedge CLK) begin : mem_model
		logic [15:0] off;
		off = memory_address - cfg_sb;
		if (rvalid && wait_cnt >= cur_delay) begin
			rready      = 1'b1;
			memory_data = mem_words[memory_address];
			hs_count    = hs_count + 1;
			if (off[15:6] == 10'd255)	// data of tile 8'hff
				ff_reqs = ff_reqs + 1;
			wait_cnt  = 0;
			rng       = xorshift(rng);
			cur_delay = (delay_max == 0) ? 0 : int'(rng % 32'(delay_max + 1));
		end else begin
			rready   = 1'b0;
			wait_cnt = rvalid ? wait_cnt + 1 : 0;
		end
	end

	task automatic fill_memory();
		for (int a = 0; a < 65536; a++)
			mem_words[a] = 16'(a * 40503) ^ 16'(a >> 5) ^ 16'h3c5a;
	endtask

	function automatic logic [16:0] map_byte_addr(input logic [9:0] y, input int col);
		logic [15:0] y_pos;
		y_pos = cfg_sy + 16'(y);
		return 17'({cfg_mb, 1'b0} + 17'(y_pos[15:4]) * 17'(256 >> cfg_stride)
			+ 17'(cfg_sx[15:4]) + 17'(col));
	endfunction

	function automatic logic [7:0] tile_at(input logic [16:0] byte_addr);
		logic [15:0] w;
		w = mem_words[byte_addr[16:1]];
		return byte_addr[0] ? w[15:8] : w[7:0];
	endfunction

	function automatic logic [7:0] expected_pixel(input logic [9:0] y, input int x);
		int          pos;
		logic [7:0]  tile;
		logic [15:0] y_pos;
		logic [15:0] w;
		pos   = x + int'(cfg_sx[3:0]);
		y_pos = cfg_sy + 16'(y);
		tile  = tile_at(map_byte_addr(y, pos / 16));
		if (tile == 8'hff)
			return {cfg_pal, 4'h0};
		w = mem_words[16'(cfg_sb + 16'(tile) * 16'd64 + 16'(y_pos[3:0]) * 16'd4
			+ 16'(pos % 16 / 4))];
		return {cfg_pal, w[(pos % 4) * 4 +: 4]};
	endfunction

	// one map read per column, four data reads per opaque tile
	function automatic int expected_handshakes(input logic [9:0] y);
		int n;
		n = NCOL;
		for (int c = 0; c < NCOL; c++)
			if (tile_at(map_byte_addr(y, c)) != 8'hff)
				n = n + 4;
		return n;
	endfunction

	task automatic report_value(input string name, input string what, input int exp,
			input int act);
		$display("[ERROR] %s: %s expected %0d actual %0d", name, what, exp, act);
		test_errs = test_errs + 1;
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, test_errs);
		errors    = errors + test_errs;
		tests_run = tests_run + 1;
		test_errs = 0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
		@(negedge CLK);
		ADDRESS = addr;
		DATA_IN = data;
		WR      = 1'b1;
		@(negedge CLK);
		WR = 1'b0;
	endtask

	task automatic configure(input logic en, input logic [3:0] pal, input logic [1:0] stride,
			input logic [15:0] sx, input logic [15:0] sy, input logic [15:0] mb,
			input logic [15:0] sb);
		write_reg(bg_pkg::REG_SCROLL_X, sx);
		write_reg(bg_pkg::REG_SCROLL_Y, sy);
		write_reg(bg_pkg::REG_MAP_BASE, mb);
		write_reg(bg_pkg::REG_SET_BASE, sb);
		write_reg(bg_pkg::REG_CTRL, {6'd0, stride, pal, 3'd0, en});
		cfg_pal    = pal;
		cfg_stride = stride;
		cfg_sx     = sx;
		cfg_sy     = sy;
		cfg_mb     = mb;
		cfg_sb     = sb;
	endtask

	task automatic mark_transparent(input logic [9:0] y, input int step, input int phase);
		logic [16:0] a;
		for (int c = phase; c < NCOL; c += step) begin
			a = map_byte_addr(y, c);
			mem_words[a[16:1]][{a[0], 3'd0} +: 8] = 8'hff;
		end
	endtask

	task automatic line_tick(input logic [9:0] y);
		@(negedge CLK);
		display_y = y;
		h_tick    = 1'b1;
		hs_base   = hs_count;
		ff_base   = ff_reqs;
		@(negedge CLK);
		h_tick = 1'b0;
	endtask

	// last tile needs at most 3 cycles after its final handshake
	task automatic wait_fetch(input string name, input int exp_hs);
		while (hs_count - hs_base < exp_hs)
			@(negedge CLK);
		repeat (4) @(negedge CLK);
		if (hs_count - hs_base != exp_hs)
			report_value(name, "handshakes", exp_hs, hs_count - hs_base);
		if (rvalid !== 1'b0)
			report_value(name, "rvalid after line end", 0, 1);
	endtask

	task automatic sweep(input string name, input logic [9:0] y, input bit blank);
		logic [7:0] exp;
		for (int i = 0; i < SCREEN_W + 2; i++) begin
			@(negedge CLK);
			if (i >= 2) begin
				exp = blank ? 8'h00 : expected_pixel(y, i - 2);
				if (color_index !== exp)
					report_value(name, $sformatf("pixel %0d", i - 2), int'(exp),
						int'(color_index));
			end
			display_x = (i < SCREEN_W) ? 10'(i) : 10'd0;
			re        = (i < SCREEN_W);
		end
	endtask

	task automatic render_line(input string name, input logic [9:0] y);
		int exp_hs;
		exp_hs = expected_handshakes(y);
		line_tick(y);
		wait_fetch(name, exp_hs);
		line_tick(y);	// swap, refetch into the other half
		sweep(name, y, 1'b0);
		wait_fetch(name, exp_hs);
	endtask

	task automatic check_reset_state();
		if (rvalid !== 1'b0)
			report_value("reset", "rvalid", 0, 1);
		sweep("reset", 10'd0, 1'b1);
		finish_test("reset");
	endtask

	task automatic render_basic();
		fill_memory();
		delay_max = 0;
		configure(1'b1, 4'h9, 2'd0, 16'd0, 16'd0, 16'h0100, 16'h4000);
		render_line("basic", 10'd5);
		finish_test("basic");
	endtask

	task automatic render_transparent();
		fill_memory();
		configure(1'b1, 4'h6, 2'd0, 16'd0, 16'd0, 16'h0100, 16'h4000);
		mark_transparent(10'd5, 4, 0);	// includes the last column
		render_line("transparent", 10'd5);
		if (ff_reqs != ff_base)
			report_value("transparent", "tile ff data reads", 0, ff_reqs - ff_base);
		finish_test("transparent");
	endtask

	task automatic render_scrolled();
		fill_memory();
		for (int code = 0; code < 4; code++) begin
			configure(1'b1, 4'(code + 2), 2'(code), 16'(37 + code * 18),
				16'(21 + code * 9), 16'h0100, 16'h4000);
			render_line("scroll", 10'(7 + code));
			// holes where the previous line had pixels
			mark_transparent(10'(8 + code), 3, code % 3);
			render_line("scroll", 10'(8 + code));
		end
		finish_test("scroll");
	endtask

	task automatic render_backpressure();
		fill_memory();
		delay_max = MAX_DELAY;
		configure(1'b1, 4'h9, 2'd0, 16'd0, 16'd0, 16'h0100, 16'h4000);
		render_line("backpressure", 10'd5);
		delay_max = 0;
		finish_test("backpressure");
	endtask

	task automatic check_disabled();
		int busy;
		busy = 0;
		configure(1'b0, 4'h0, 2'd0, 16'd0, 16'd0, 16'h0100, 16'h4000);
		line_tick(10'd5);
		repeat (NCOL * 7) begin
			@(negedge CLK);
			busy = busy + int'(rvalid);
		end
		if (busy != 0)
			report_value("disable", "cycles with rvalid", 0, busy);
		sweep("disable", 10'd5, 1'b1);
		finish_test("disable");
	endtask

	initial begin
		RSTb      = 1'b0;
		ADDRESS   = 4'd0;
		DATA_IN   = 16'h0000;
		WR        = 1'b0;
		h_tick    = 1'b0;
		display_x = 10'd0;
		display_y = 10'd0;
		re        = 1'b0;
		hs_base   = 0;
		ff_base   = 0;
		errors    = 0;
		test_errs = 0;
		tests_run = 0;
		configure_defaults: begin
			cfg_pal    = 4'h0;
			cfg_stride = 2'd0;
			cfg_sx     = 16'h0000;
			cfg_sy     = 16'h0000;
			cfg_mb     = 16'h0000;
			cfg_sb     = 16'h0000;
		end
		fill_memory();
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;
		@(negedge CLK);

		check_reset_state();
		render_basic();
		render_transparent();
		render_scrolled();
		render_backpressure();
		check_disabled();

		errors = errors + i_bg_renderer.u_fetch.u_assert.fail_count;
		$display("tests %0d, errors %0d, assertion failures %0d", tests_run, errors,
			i_bg_renderer.u_fetch.u_assert.fail_count);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- project.f
src/bg_pkg.sv
src/mem_rd_if.sv
src/bram.sv
src/bg_regs.sv
src/tile_fetch.sv
src/scanline_store.sv
src/bg_renderer.sv
tests/bg_renderer_assert.sv
tests/tb_bg_renderer.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and fail unless the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_bg_renderer -f project.f \
	&& ./obj_dir/Vtb_bg_renderer +verilator+error+limit+100 | tee /dev/stderr \
	| grep "SIMULATION PASSED" > /dev/null \
	&& echo "run: pass" \
	|| { echo "run: fail"; exit 1; }
